/* design/lsram_consts.svh */
`ifndef LSRAM_CONSTS_SVH
`define LSRAM_CONSTS_SVH

// AXI4-Lite byte address width.
`define LSRAM_AXI_ADDR_W 12

// data word and byte lane geometry.
`define LSRAM_DATA_W     32
`define LSRAM_LANE_W     8
`define LSRAM_N_LANES    4

// word index widths of the two storage regions.
`define LSRAM_RAM_ADDR_W 8
`define LSRAM_REG_ADDR_W 4

`endif

/* design/lsram_pkg.sv */
`default_nettype none

`include "lsram_consts.svh"

package lsram_pkg;

   typedef logic [`LSRAM_AXI_ADDR_W-1:0] axi_addr_t; // byte address.
   typedef logic [`LSRAM_DATA_W-1:0]     data_t;
   typedef logic [`LSRAM_N_LANES-1:0]    strb_t;     // strobe and lane enable.
   typedef logic [`LSRAM_RAM_ADDR_W-1:0] ram_addr_t;
   typedef logic [`LSRAM_REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [1:0]                   resp_t;

   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

   // one transaction at a time, so a single FSM covers both channels.
   typedef enum logic [2:0]
   {
      IDLE,
      WRITE,
      WRESP,
      READ,
      RDATA
   } slave_state_e;

endpackage

`default_nettype wire

/* design/byte_lane_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsram_consts.svh"

module byte_lane_ram
#(
   parameter int ADDR_W = `LSRAM_RAM_ADDR_W
)
(
   input  logic                clk,
   input  logic [ADDR_W-1:0]   addr,
   input  lsram_pkg::data_t    wdata,
   input  lsram_pkg::strb_t    lane_en,
   output lsram_pkg::data_t    rdata
);

   localparam int DEPTH = 1 << ADDR_W;

   for (genvar i = 0; i < `LSRAM_N_LANES; i++)
   begin : g_lane
      logic [`LSRAM_LANE_W-1:0] mem [0:DEPTH-1];
      logic [`LSRAM_LANE_W-1:0] rd_q;

      // a lane either writes or reads in a given cycle.
      always_ff @(posedge clk)
      begin
         if (lane_en[i])
         begin
            mem[addr] <= wdata[i*`LSRAM_LANE_W +: `LSRAM_LANE_W];
         end
         else
         begin
            rd_q <= mem[addr]; // registered read.
         end
      end

      assign rdata[i*`LSRAM_LANE_W +: `LSRAM_LANE_W] = rd_q;
   end

endmodule

`default_nettype wire

/* design/byte_lane_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsram_consts.svh"

module byte_lane_regfile
#(
   parameter int ADDR_W = `LSRAM_REG_ADDR_W
)
(
   input  logic                clk,
   input  logic                rst,
   input  logic [ADDR_W-1:0]   addr,
   input  lsram_pkg::data_t    wdata,
   input  lsram_pkg::strb_t    lane_en,
   output lsram_pkg::data_t    rdata
);

   localparam int DEPTH = 1 << ADDR_W;

   for (genvar i = 0; i < `LSRAM_N_LANES; i++)
   begin : g_lane
      logic [`LSRAM_LANE_W-1:0] mem [0:DEPTH-1];

      always_ff @(posedge clk)
      begin
         if (rst)
         begin
            for (int j = 0; j < DEPTH; j++)
            begin
               mem[j] <= '0; // whole file clears.
            end
         end
         else if (lane_en[i])
         begin
            mem[addr] <= wdata[i*`LSRAM_LANE_W +: `LSRAM_LANE_W];
         end
      end

      // combinational read, no latency.
      assign rdata[i*`LSRAM_LANE_W +: `LSRAM_LANE_W] = mem[addr];
   end

endmodule

`default_nettype wire

/* design/axil_mem_slave.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsram_consts.svh"

module axil_mem_slave
(
   input  logic                   clk,
   input  logic                   rst,

   input  logic                   awvalid,
   output logic                   awready,
   input  lsram_pkg::axi_addr_t   awaddr,

   input  logic                   wvalid,
   output logic                   wready,
   input  lsram_pkg::data_t       wdata,
   input  lsram_pkg::strb_t       wstrb,

   output logic                   bvalid,
   input  logic                   bready,
   output lsram_pkg::resp_t       bresp,

   input  logic                   arvalid,
   output logic                   arready,
   input  lsram_pkg::axi_addr_t   araddr,

   output logic                   rvalid,
   input  logic                   rready,
   output lsram_pkg::data_t       rdata,
   output lsram_pkg::resp_t       rresp,

   output lsram_pkg::ram_addr_t   mem_addr,
   output lsram_pkg::data_t       mem_wdata,
   output lsram_pkg::strb_t       ram_en,
   output lsram_pkg::strb_t       reg_en,
   input  lsram_pkg::data_t       ram_rdata,
   input  lsram_pkg::data_t       reg_rdata
);

   // address map bit positions.
   localparam int REGION_BIT = `LSRAM_AXI_ADDR_W - 1;
   localparam int RANGE_HI   = `LSRAM_AXI_ADDR_W - 2;
   localparam int RANGE_LO   = 2 + `LSRAM_REG_ADDR_W;
   localparam int WORD_LO    = 2;

   lsram_pkg::slave_state_e state;
   lsram_pkg::slave_state_e state_nxt;

   lsram_pkg::axi_addr_t    addr_q;
   lsram_pkg::data_t        wdata_q;
   lsram_pkg::strb_t        strb_q;

   logic                    wr_hs;
   logic                    rd_hs;
   logic                    sel_reg;
   logic                    out_of_range;
   lsram_pkg::data_t        rd_sel;
   lsram_pkg::resp_t        acc_resp;

   // write pair wins a tie with a pending read.
   assign wr_hs   = (state == lsram_pkg::IDLE) && awvalid && wvalid;
   assign rd_hs   = (state == lsram_pkg::IDLE) && arvalid && !(awvalid && wvalid);
   assign awready = wr_hs;
   assign wready  = wr_hs;
   assign arready = rd_hs;

   assign sel_reg      = addr_q[REGION_BIT];
   assign out_of_range = sel_reg && (|addr_q[RANGE_HI:RANGE_LO]);
   assign acc_resp     = out_of_range ? lsram_pkg::RESP_SLVERR : lsram_pkg::RESP_OKAY;

   // bit 10 is dropped here, so the RAM half aliases.
   assign mem_addr  = addr_q[WORD_LO +: `LSRAM_RAM_ADDR_W];
   assign mem_wdata = wdata_q;

   // strobes reach storage only for the single WRITE cycle.
   assign ram_en = (state == lsram_pkg::WRITE && !sel_reg) ? strb_q : '0;
   assign reg_en = (state == lsram_pkg::WRITE && sel_reg && !out_of_range) ? strb_q : '0;

   always_comb
   begin
      if (out_of_range)
      begin
         rd_sel = '0;
      end
      else if (sel_reg)
      begin
         rd_sel = reg_rdata;
      end
      else
      begin
         rd_sel = ram_rdata;
      end
   end

   always_comb
   begin
      state_nxt = state;
      case (state)
         lsram_pkg::IDLE:
         begin
            if (wr_hs)
            begin
               state_nxt = lsram_pkg::WRITE;
            end
            else if (rd_hs)
            begin
               state_nxt = lsram_pkg::READ;
            end
         end
         lsram_pkg::WRITE: state_nxt = lsram_pkg::WRESP;
         lsram_pkg::WRESP:
         begin
            if (bready)
            begin
               state_nxt = lsram_pkg::IDLE; // bvalid is high all through WRESP.
            end
         end
         lsram_pkg::READ:  state_nxt = lsram_pkg::RDATA; // RAM read issued here.
         lsram_pkg::RDATA:
         begin
            if (rvalid && rready)
            begin
               state_nxt = lsram_pkg::IDLE;
            end
         end
         default: state_nxt = lsram_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state  <= lsram_pkg::IDLE;
         bvalid <= 1'b0;
         rvalid <= 1'b0;
      end
      else
      begin
         state <= state_nxt;
         if (state == lsram_pkg::WRITE)
         begin
            bvalid <= 1'b1;
         end
         else if (bvalid && bready)
         begin
            bvalid <= 1'b0;
         end
         if (state == lsram_pkg::RDATA && !rvalid)
         begin
            rvalid <= 1'b1; // two cycles after AR.
         end
         else if (rvalid && rready)
         begin
            rvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_hs)
      begin
         addr_q  <= awaddr;
         wdata_q <= wdata;
         strb_q  <= wstrb;
      end
      else if (rd_hs)
      begin
         addr_q <= araddr;
      end
      if (state == lsram_pkg::WRITE)
      begin
         bresp <= acc_resp;
      end
      if (state == lsram_pkg::RDATA && !rvalid)
      begin
         rdata <= rd_sel; // held until rready.
         rresp <= acc_resp;
      end
   end

endmodule

`default_nettype wire

/* design/lsram_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsram_consts.svh"

module lsram_top
(
   input  logic                   clk,
   input  logic                   rst,

   input  logic                   awvalid,
   output logic                   awready,
   input  lsram_pkg::axi_addr_t   awaddr,

   input  logic                   wvalid,
   output logic                   wready,
   input  lsram_pkg::data_t       wdata,
   input  lsram_pkg::strb_t       wstrb,

   output logic                   bvalid,
   input  logic                   bready,
   output lsram_pkg::resp_t       bresp,

   input  logic                   arvalid,
   output logic                   arready,
   input  lsram_pkg::axi_addr_t   araddr,

   output logic                   rvalid,
   input  logic                   rready,
   output lsram_pkg::data_t       rdata,
   output lsram_pkg::resp_t       rresp
);

   lsram_pkg::ram_addr_t mem_addr;
   lsram_pkg::data_t     mem_wdata;
   lsram_pkg::strb_t     ram_en;
   lsram_pkg::strb_t     reg_en;
   lsram_pkg::data_t     ram_rdata;
   lsram_pkg::data_t     reg_rdata;

   axil_mem_slave u_slave
   (
      .clk       (clk),
      .rst       (rst),
      .awvalid   (awvalid),
      .awready   (awready),
      .awaddr    (awaddr),
      .wvalid    (wvalid),
      .wready    (wready),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .bvalid    (bvalid),
      .bready    (bready),
      .bresp     (bresp),
      .arvalid   (arvalid),
      .arready   (arready),
      .araddr    (araddr),
      .rvalid    (rvalid),
      .rready    (rready),
      .rdata     (rdata),
      .rresp     (rresp),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .ram_en    (ram_en),
      .reg_en    (reg_en),
      .ram_rdata (ram_rdata),
      .reg_rdata (reg_rdata)
   );

   byte_lane_ram #(.ADDR_W(`LSRAM_RAM_ADDR_W)) u_ram
   (
      .clk     (clk),
      .addr    (mem_addr),
      .wdata   (mem_wdata),
      .lane_en (ram_en),
      .rdata   (ram_rdata)
   );

   // register file takes the low bits of the shared word index.
   byte_lane_regfile #(.ADDR_W(`LSRAM_REG_ADDR_W)) u_regfile
   (
      .clk     (clk),
      .rst     (rst),
      .addr    (mem_addr[`LSRAM_REG_ADDR_W-1:0]),
      .wdata   (mem_wdata),
      .lane_en (reg_en),
      .rdata   (reg_rdata)
   );

endmodule

`default_nettype wire

/* dv/lsram_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module lsram_assert
(
   input logic                    clk,
   input logic                    rst,
   input lsram_pkg::slave_state_e state,
   input logic                    awready,
   input logic                    arvalid,
   input logic                    arready,
   input logic                    bvalid,
   input logic                    bready,
   input lsram_pkg::resp_t        bresp,
   input logic                    rvalid,
   input logic                    rready,
   input lsram_pkg::data_t        rdata,
   input lsram_pkg::resp_t        rresp,
   input lsram_pkg::strb_t        ram_en,
   input lsram_pkg::strb_t        reg_en
);

   int fails = 0;

   a_b_hold: assert property (@(posedge clk) disable iff (rst)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else begin $error("bvalid or bresp changed before bready"); fails++; end

   a_r_hold: assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
      else begin $error("rvalid or its payload changed before rready"); fails++; end

   a_ready_excl: assert property (@(posedge clk) disable iff (rst) !(awready && arready))
      else begin $error("awready and arready high together"); fails++; end

   // rvalid rises two edges after the AR handshake, so it is sampled high three ticks on.
   a_r_latency: assert property (@(posedge clk) disable iff (rst)
      $rose(rvalid) == $past(arvalid && arready, 3))
      else begin $error("rvalid did not rise two cycles after AR"); fails++; end

   a_en_excl: assert property (@(posedge clk) disable iff (rst) !((|ram_en) && (|reg_en)))
      else begin $error("RAM and register file enabled together"); fails++; end

   a_r_state: assert property (@(posedge clk) disable iff (rst)
      rvalid |-> state == lsram_pkg::RDATA)
      else begin $error("rvalid outside RDATA"); fails++; end

endmodule

bind axil_mem_slave lsram_assert u_assert
(
   .clk     (clk),
   .rst     (rst),
   .state   (state),
   .awready (awready),
   .arvalid (arvalid),
   .arready (arready),
   .bvalid  (bvalid),
   .bready  (bready),
   .bresp   (bresp),
   .rvalid  (rvalid),
   .rready  (rready),
   .rdata   (rdata),
   .rresp   (rresp),
   .ram_en  (ram_en),
   .reg_en  (reg_en)
);

`default_nettype wire

/* dv/lsram_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsram_tb;

   localparam int CLK_NS      = 40;
   localparam int WATCHDOG_NS = (300 * 10 + 10) * CLK_NS; // ops x 10 cycles, plus reset.

   logic clk;
   logic rst;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   lsram_pkg::axi_addr_t awaddr, araddr;
   lsram_pkg::data_t     wdata, rdata;
   lsram_pkg::strb_t     wstrb;
   lsram_pkg::resp_t     bresp, rresp;

   lsram_pkg::data_t     ram_m [0:255]; // expected contents of both regions.
   lsram_pkg::data_t     reg_m [0:15];
   int                   cyc;
   int                   n_checks;
   int                   n_errors;
   int                   last_checks;
   int                   last_errors;

   // responses waiting for the checker.
   logic                 q_read [$];
   lsram_pkg::axi_addr_t q_addr [$];
   lsram_pkg::data_t     q_exp_data [$];
   lsram_pkg::data_t     q_got_data [$];
   lsram_pkg::resp_t     q_exp_resp [$];
   lsram_pkg::resp_t     q_got_resp [$];
   int                   q_lat [$];

   lsram_top dut0 (.*);

   initial
   begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   always @(posedge clk)
   begin
      cyc <= cyc + 1; // edge counter for read latency.
   end

   function automatic logic is_bad(input lsram_pkg::axi_addr_t a);
      return a[11] && (|a[10:6]); // register half, bits 10:6 must be clear.
   endfunction

   function automatic lsram_pkg::resp_t ref_resp(input lsram_pkg::axi_addr_t a);
      return is_bad(a) ? 2'b10 : 2'b00;
   endfunction

   function automatic lsram_pkg::data_t ref_data(input lsram_pkg::axi_addr_t a);
      if (is_bad(a))
      begin
         return '0;
      end
      return a[11] ? reg_m[a[5:2]] : ram_m[a[9:2]]; // bit 10 aliases in the RAM half.
   endfunction

   task automatic model_write(input lsram_pkg::axi_addr_t a, input lsram_pkg::data_t d,
                              input lsram_pkg::strb_t s);
      lsram_pkg::data_t word;
      if (is_bad(a))
      begin
         return;
      end
      word = ref_data(a);
      for (int i = 0; i < 4; i++)
      begin
         if (s[i])
         begin
            word[i*8 +: 8] = d[i*8 +: 8]; // strobed bytes only.
         end
      end
      if (a[11])
      begin
         reg_m[a[5:2]] = word;
      end
      else
      begin
         ram_m[a[9:2]] = word;
      end
   endtask

   task automatic record(input logic rd, input lsram_pkg::axi_addr_t a,
                         input lsram_pkg::data_t ed, input lsram_pkg::data_t gd,
                         input lsram_pkg::resp_t er, input lsram_pkg::resp_t gr, input int lat);
      q_read.push_back(rd);
      q_addr.push_back(a);
      q_exp_data.push_back(ed);
      q_got_data.push_back(gd);
      q_exp_resp.push_back(er);
      q_got_resp.push_back(gr);
      q_lat.push_back(lat);
   endtask

   task automatic axil_write(input lsram_pkg::axi_addr_t a, input lsram_pkg::data_t d,
                             input lsram_pkg::strb_t s);
      logic             hs;
      int               delay;
      lsram_pkg::resp_t resp;
      delay   = $urandom_range(0, 2);
      awvalid = 1'b1;
      awaddr  = a;
      wvalid  = 1'b1;
      wdata   = d;
      wstrb   = s;
      hs      = 1'b0;
      while (!hs)
      begin
         @(negedge clk);
         hs = awready && wready;
         @(posedge clk);
         #2;
      end
      awvalid = 1'b0;
      wvalid  = 1'b0;
      repeat (delay)
      begin
         @(posedge clk);
         #2;
      end
      bready = 1'b1;
      hs     = 1'b0;
      while (!hs)
      begin
         @(negedge clk);
         hs   = bvalid;
         resp = bresp;
         @(posedge clk);
         #2;
      end
      bready = 1'b0;
      record(1'b0, a, '0, '0, ref_resp(a), resp, 0);
      model_write(a, d, s);
   endtask

   task automatic axil_read(input lsram_pkg::axi_addr_t a);
      logic             hs;
      int               t0;
      int               t1;
      int               delay;
      lsram_pkg::data_t got;
      lsram_pkg::resp_t resp;
      delay   = $urandom_range(0, 2);
      arvalid = 1'b1;
      araddr  = a;
      hs      = 1'b0;
      while (!hs)
      begin
         @(negedge clk);
         hs = arready;
         t0 = cyc + 1; // index of the AR handshake edge.
         @(posedge clk);
         #2;
      end
      arvalid = 1'b0;
      @(negedge clk);
      while (!rvalid)
      begin
         @(negedge clk);
      end
      t1 = cyc;
      @(posedge clk);
      #2;
      repeat (delay)
      begin
         @(posedge clk);
         #2;
      end
      rready = 1'b1;
      hs     = 1'b0;
      while (!hs)
      begin
         @(negedge clk);
         hs   = rvalid;
         got  = rdata;
         resp = rresp;
         @(posedge clk);
         #2;
      end
      rready = 1'b0;
      record(1'b1, a, ref_data(a), got, ref_resp(a), resp, t1 - t0);
   endtask

   task automatic compare_one;
      logic                 rd;
      lsram_pkg::axi_addr_t a;
      lsram_pkg::data_t     ed;
      lsram_pkg::data_t     gd;
      lsram_pkg::resp_t     er;
      lsram_pkg::resp_t     gr;
      int                   lat;
      rd  = q_read.pop_front();
      a   = q_addr.pop_front();
      ed  = q_exp_data.pop_front();
      gd  = q_got_data.pop_front();
      er  = q_exp_resp.pop_front();
      gr  = q_got_resp.pop_front();
      lat = q_lat.pop_front();
      n_checks++;
      if (rd && gd !== ed)
      begin
         $display("FAIL %0t rdata addr=%h exp=%h got=%h", $time, a, ed, gd);
         n_errors++;
      end
      if (gr !== er)
      begin
         $display("FAIL %0t %s addr=%h exp=%0d got=%0d", $time, rd ? "rresp" : "bresp",
                  a, er, gr);
         n_errors++;
      end
      if (rd && lat != 2)
      begin
         $display("FAIL %0t rvalid latency addr=%h exp=2 got=%0d", $time, a, lat);
         n_errors++;
      end
   endtask

   always @(posedge clk)
   begin
      while (q_addr.size() > 0)
      begin
         compare_one();
      end
   end

   task automatic end_test(input string name);
      while (q_addr.size() > 0)
      begin
         @(posedge clk);
         #2;
      end
      $display("test %s: %0d checks, %0d errors", name, n_checks - last_checks,
               n_errors - last_errors);
      last_checks = n_checks;
      last_errors = n_errors;
   endtask

   initial
   begin
      logic [31:0]          r;
      lsram_pkg::data_t     d;
      lsram_pkg::axi_addr_t a;
      void'($urandom(14));
      rst     = 1'b1;
      awvalid = 1'b0;
      awaddr  = '0;
      wvalid  = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      bready  = 1'b0;
      arvalid = 1'b0;
      araddr  = '0;
      rready  = 1'b0;
      for (int i = 0; i < 256; i++)
      begin
         ram_m[i] = '0;
      end
      for (int i = 0; i < 16; i++)
      begin
         reg_m[i] = '0;
      end
      repeat (10) @(posedge clk);
      #2;
      rst = 1'b0;

      for (int i = 0; i < 16; i++)
      begin
         axil_read(12'h800 + 12'(i * 4));
      end
      end_test("regfile_after_reset");

      axil_write(12'h000, 32'h0123_4567, 4'hF);
      axil_write(12'h004, 32'h89AB_CDEF, 4'hF);
      axil_write(12'h3FC, 32'hDEAD_BEEF, 4'hF);
      axil_write(12'h410, 32'hCAFE_F00D, 4'hF); // bit 10 set, lands on word 4.
      axil_read(12'h000);
      axil_read(12'h004);
      axil_read(12'h7FC);
      axil_read(12'h010);
      end_test("ram_full_strobe");

      axil_write(12'h014, 32'hFFFF_FFFF, 4'hF);
      axil_write(12'h014, 32'h1122_3344, 4'b0101);
      axil_read(12'h014);
      axil_write(12'h80C, 32'hA5A5_A5A5, 4'hF);
      axil_write(12'h80C, 32'h5566_7788, 4'b1000);
      axil_write(12'h80C, 32'h0000_00EE, 4'b0001);
      axil_read(12'h80C);
      end_test("partial_strobe");

      axil_write(12'h81C, 32'h7777_0007, 4'hF);
      axil_write(12'h01C, 32'h0001_C01C, 4'hF);
      axil_read(12'h81C);
      axil_read(12'h01C);
      end_test("region_independence");

      axil_write(12'h840, 32'hBAD0_0040, 4'hF);
      axil_write(12'hC0C, 32'hBAD0_0C0C, 4'hF);
      axil_read(12'h840);
      axil_read(12'hFFC);
      for (int i = 0; i < 16; i++)
      begin
         axil_read(12'h800 + 12'(i * 4)); // nothing stored may have moved.
      end
      end_test("out_of_range");

      // random RAM traffic stays in words 0 to 31, filled first.
      for (int i = 0; i < 32; i++)
      begin
         axil_write({5'b0, 5'(i), 2'b00}, 32'h9E37_79B9 * 32'(i + 1), 4'hF);
      end
      for (int i = 0; i < 200; i++)
      begin
         r = $urandom();
         d = $urandom();
         if (r[0])
         begin
            a = {1'b0, r[10], 3'b000, r[6:2], r[1:0]};
         end
         else if (r[14:12] == 3'd0)
         begin
            a = {1'b1, r[25:15]}; // mostly out of range.
         end
         else
         begin
            a = {1'b1, 5'b00000, r[19:16], r[21:20]};
         end
         if (r[27])
         begin
            axil_write(a, d, r[31:28]);
         end
         else
         begin
            axil_read(a);
         end
      end
      end_test("random_traffic");

      $display("done: %0d checks, %0d errors, %0d assertion failures", n_checks, n_errors,
               dut0.u_slave.u_assert.fails);
      if (n_errors == 0 && dut0.u_slave.u_assert.fails == 0)
      begin
         $display("TB PASSED");
      end
      else
      begin
         $display("TB FAILED");
      end
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
      $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+design
design/lsram_pkg.sv
design/byte_lane_ram.sv
design/byte_lane_regfile.sv
design/axil_mem_slave.sv
design/lsram_top.sv
dv/lsram_assert.sv
dv/lsram_tb.sv

/* Makefile */
TOP := lsram_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f \
		-Mdir obj_dir -o $(TOP)

# the log decides pass or fail.
run: compile
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -qx "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
